// ==== files.f ====
+incdir+common
common/fdc_pkg.sv
hdl/host_port.sv
sequencer/cmd_sequencer.sv
hdl/seek_unit.sv
hdl/fdc_top.sv
tb/fdc_properties.sv
tb/fdc_tb.sv

// ==== tb/fdc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fdc_settings.svh"

module fdc_tb;

	localparam logic [2:0] ACT_WRITE  = 3'd0; // data register write
	localparam logic [2:0] ACT_READ   = 3'd1; // data register read
	localparam logic [2:0] ACT_STATUS = 3'd2; // main status read
	localparam logic [2:0] ACT_POLL   = 3'd3; // status reads until value bits clear
	localparam logic [2:0] ACT_CTRL   = 3'd4; // drive lines and fast mode
	localparam logic [2:0] ACT_SPAN   = 3'd5; // value = step-rate ms since the last write

	// one step-rate millisecond, timer reload included
	localparam longint MS_CYCLES = `FDC_CYCLES_PER_MS + 1;

	typedef struct packed {
		logic [2:0] action;
		logic [7:0] value;
		logic [7:0] expected;
		logic [7:0] mask;
	} entry_t;

	logic       clk_sys;
	logic       reset;
	logic [1:0] ready;
	logic [1:0] motor;
	logic [1:0] available;
	logic       fast;
	logic       a0;
	logic       nrd;
	logic       nwr;
	logic [7:0] din;
	logic [7:0] dout;

	entry_t steps [0:79];
	int     table_len;
	logic   table_ready;
	int     check_cnt;
	int     error_cnt;

	fdc_top fdc_top_i (
		.i_clk_sys   (clk_sys),
		.i_reset     (reset),
		.i_ready     (ready),
		.i_motor     (motor),
		.i_available (available),
		.i_fast      (fast),
		.i_a0        (a0),
		.i_nrd       (nrd),
		.i_nwr       (nwr),
		.i_din       (din),
		.o_dout      (dout)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// control byte layout {0, available, ready, motor, fast}
	function automatic logic [7:0] ctrl_byte(input logic f, input logic [1:0] m,
		input logic [1:0] r, input logic [1:0] a);
		ctrl_byte = {1'b0, a, r, m, f};
	endfunction

	task automatic add_entry(input logic [2:0] action, input logic [7:0] value,
		input logic [7:0] expected, input logic [7:0] mask);
		steps[table_len] = '{action, value, expected, mask};
		table_len++;
	endtask

	// strobe low two cycles, high two cycles, entered and left on a falling edge
	task automatic host_access(input logic sel, input logic is_read, input logic [7:0] wdata,
		output logic [7:0] rdata);
		a0  = sel;
		din = wdata;
		if (is_read) nrd = 1'b0;
		else nwr = 1'b0;
		repeat (2) @(negedge clk_sys);
		rdata = dout; // settled since the last rising edge
		nrd   = 1'b1;
		nwr   = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] exp,
		input logic [7:0] mask);
		check_cnt++;
		if ((got & mask) !== (exp & mask)) begin
			error_cnt++;
			$display("CHECK FAILED at %0t: entry %0d read %02h, expected %02h under mask %02h",
				$time, idx, got, exp, mask);
		end
	endtask

	// ========================================================================
	// watchdog
	// ========================================================================

	initial begin
		longint timeout_cycles;
		wait (table_ready === 1'b1);
		timeout_cycles = table_len * 200 + 20 * 16 * (`FDC_CYCLES_PER_MS + 1);
		repeat (timeout_cycles) @(posedge clk_sys);
		$display("run timed out after %0d cycles, the DUT stopped responding", timeout_cycles);
		$display("Finished with errors");
		$finish;
	end

	// ========================================================================
	// stimulus table and main loop
	// ========================================================================

	initial begin
		logic [7:0] rd;
		time        write_time;
		longint     span;
		reset       = 1'b1;
		ready       = 2'b11;
		motor       = 2'b11;
		available   = 2'b11;
		fast        = 1'b1;
		a0          = 1'b0;
		nrd         = 1'b1;
		nwr         = 1'b1;
		din         = 8'h00;
		check_cnt   = 0;
		error_cnt   = 0;
		table_len   = 0;
		table_ready = 1'b0;
		write_time  = 0;

		// reset values, idle data read
		add_entry(ACT_STATUS, 8'h00, 8'h80, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'hff, 8'hff);
		// invalid opcode
		add_entry(ACT_WRITE, 8'h1f, 8'h00, 8'h00);
		add_entry(ACT_STATUS, 8'h00, 8'hd0, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h80, 8'hff);
		add_entry(ACT_STATUS, 8'h00, 8'h80, 8'hff);
		// fast seek drive 0 to 5, sense int twice, recal drive 1
		add_entry(ACT_CTRL, ctrl_byte(1'b1, 2'b11, 2'b11, 2'b11), 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h0f, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h00, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h05, 8'h00, 8'h00);
		add_entry(ACT_POLL, 8'h01, 8'h80, 8'hff);
		add_entry(ACT_WRITE, 8'h08, 8'h00, 8'h00);
		add_entry(ACT_STATUS, 8'h00, 8'hd0, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h20, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h05, 8'hff);
		add_entry(ACT_WRITE, 8'h08, 8'h00, 8'h00);
		add_entry(ACT_READ, 8'h00, 8'h80, 8'hff);
		add_entry(ACT_WRITE, 8'h07, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h01, 8'h00, 8'h00);
		add_entry(ACT_POLL, 8'h02, 8'h80, 8'hff);
		add_entry(ACT_WRITE, 8'h08, 8'h00, 8'h00);
		add_entry(ACT_READ, 8'h00, 8'h21, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h00, 8'hff);
		// specify srt 15, slow seek 5 -> 3
		add_entry(ACT_WRITE, 8'h03, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'hf0, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h00, 8'h00, 8'h00);
		add_entry(ACT_CTRL, ctrl_byte(1'b0, 2'b11, 2'b11, 2'b11), 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h0f, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h00, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h03, 8'h00, 8'h00);
		add_entry(ACT_STATUS, 8'h00, 8'h01, 8'h01); // d0b while stepping
		add_entry(ACT_POLL, 8'h01, 8'h80, 8'hff);
		add_entry(ACT_SPAN, 8'd2, 8'h00, 8'h00); // two steps of (16 - 15) ms
		add_entry(ACT_WRITE, 8'h08, 8'h00, 8'h00);
		add_entry(ACT_READ, 8'h00, 8'h20, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h03, 8'hff);
		// refused seeks beyond the limit and with motor off
		add_entry(ACT_CTRL, ctrl_byte(1'b1, 2'b11, 2'b11, 2'b11), 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h0f, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h00, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h5a, 8'h00, 8'h00);
		add_entry(ACT_STATUS, 8'h00, 8'h80, 8'hff);
		add_entry(ACT_WRITE, 8'h08, 8'h00, 8'h00);
		add_entry(ACT_READ, 8'h00, 8'he8, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h03, 8'hff);
		add_entry(ACT_CTRL, ctrl_byte(1'b1, 2'b10, 2'b11, 2'b11), 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h0f, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h00, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h07, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h08, 8'h00, 8'h00);
		add_entry(ACT_READ, 8'h00, 8'he8, 8'hff);
		add_entry(ACT_READ, 8'h00, 8'h03, 8'hff);
		// sense drive status
		add_entry(ACT_CTRL, ctrl_byte(1'b1, 2'b11, 2'b11, 2'b11), 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h04, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h05, 8'h00, 8'h00); // drive 1 head 1
		add_entry(ACT_READ, 8'h00, 8'h35, 8'hff);
		add_entry(ACT_CTRL, ctrl_byte(1'b1, 2'b11, 2'b11, 2'b10), 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h04, 8'h00, 8'h00);
		add_entry(ACT_WRITE, 8'h04, 8'h00, 8'h00); // drive 0 head 1
		add_entry(ACT_READ, 8'h00, 8'h04, 8'hff);
		table_ready = 1'b1;

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		for (int n = 0; n < table_len; n++) begin
			case (steps[n].action)
				ACT_WRITE: begin
					host_access(1'b1, 1'b0, steps[n].value, rd);
					write_time = $time;
				end
				ACT_READ: begin
					host_access(1'b1, 1'b1, 8'h00, rd);
					check_byte(n, rd, steps[n].expected, steps[n].mask);
				end
				ACT_STATUS: begin
					host_access(1'b0, 1'b1, 8'h00, rd);
					check_byte(n, rd, steps[n].expected, steps[n].mask);
				end
				ACT_POLL: begin
					rd = steps[n].value;
					while ((rd & steps[n].value) != 8'h00) begin
						host_access(1'b0, 1'b1, 8'h00, rd);
					end
					check_byte(n, rd, steps[n].expected, steps[n].mask);
				end
				ACT_SPAN: begin
					span = ($time - write_time) / 100; // 100 ns clock
					check_cnt++;
					if ((span <= (steps[n].value - 1) * MS_CYCLES) ||
						(span >= (steps[n].value + 1) * MS_CYCLES)) begin
						error_cnt++;
						$display("CHECK FAILED at %0t: entry %0d seek took %0d cycles, expected %0d",
							$time, n, span, steps[n].value * MS_CYCLES);
					end
				end
				default: begin
					fast      = steps[n].value[0];
					motor     = steps[n].value[2:1];
					ready     = steps[n].value[4:3];
					available = steps[n].value[6:5];
					@(negedge clk_sys);
				end
			endcase
		end

		$display("checks %0d, errors %0d", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/fdc_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fdc_settings.svh"

module fdc_properties (
	input  wire                      i_clk_sys,
	input  wire                      i_reset,
	input  wire  [7:0]               i_status,
	input  wire fdc_pkg::host_req_t  i_req,
	input  wire fdc_pkg::seek_stat_t i_stat_0,
	input  wire fdc_pkg::seek_stat_t i_stat_1
);

	// result phase only inside a command
	dio_needs_cb: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		i_status[`FDC_MS_DIO] |-> i_status[`FDC_MS_CB])
		else $error("DIO set in main status while CB is clear");

	wr_stb_single: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		i_req.wr_stb |=> !i_req.wr_stb)
		else $error("write strobe held for two cycles");

	rd_stb_single: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		i_req.rd_stb |=> !i_req.rd_stb)
		else $error("read strobe held for two cycles");

	// refused seeks never step, so the head stays on the disk
	pcn_0_limit: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		i_stat_0.pcn < `FDC_MAX_TRACKS)
		else $error("drive 0 cylinder beyond track limit");

	pcn_1_limit: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		i_stat_1.pcn < `FDC_MAX_TRACKS)
		else $error("drive 1 cylinder beyond track limit");

endmodule

bind fdc_top fdc_properties fdc_properties_i (
	.i_clk_sys (i_clk_sys),
	.i_reset   (i_reset),
	.i_status  (status),
	.i_req     (host_req),
	.i_stat_0  (seek_stat[0]),
	.i_stat_1  (seek_stat[1])
);

`default_nettype wire

// ==== hdl/fdc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fdc_top (
	input  wire       i_clk_sys,
	input  wire       i_reset,
	input  wire [1:0] i_ready,
	input  wire [1:0] i_motor,
	input  wire [1:0] i_available,
	input  wire       i_fast,
	input  wire       i_a0,
	input  wire       i_nrd,
	input  wire       i_nwr,
	input  wire [7:0] i_din,
	output logic [7:0] o_dout
);

	fdc_pkg::host_req_t  host_req;
	fdc_pkg::seek_req_t  seek_req [2];
	fdc_pkg::seek_stat_t seek_stat [2];
	logic [7:0]          status;
	logic [7:0]          data;
	logic [3:0]          srt;

	host_port host_port_i (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_a0      (i_a0),
		.i_nrd     (i_nrd),
		.i_nwr     (i_nwr),
		.i_din     (i_din),
		.i_status  (status),
		.i_data    (data),
		.o_req     (host_req),
		.o_dout    (o_dout)
	);

	cmd_sequencer cmd_sequencer_i (
		.i_clk_sys   (i_clk_sys),
		.i_reset     (i_reset),
		.i_req       (host_req),
		.i_ready     (i_ready),
		.i_motor     (i_motor),
		.i_available (i_available),
		.i_seek_stat (seek_stat),
		.o_seek_req  (seek_req),
		.o_srt       (srt),
		.o_status    (status),
		.o_data      (data)
	);

	// one positioner per drive
	seek_unit seek_unit_0 (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_fast    (i_fast),
		.i_srt     (srt),
		.i_req     (seek_req[0]),
		.o_stat    (seek_stat[0])
	);

	seek_unit seek_unit_1 (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_fast    (i_fast),
		.i_srt     (srt),
		.i_req     (seek_req[1]),
		.o_stat    (seek_stat[1])
	);

endmodule

`default_nettype wire

// ==== hdl/seek_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fdc_settings.svh"

module seek_unit (
	input  wire        i_clk_sys,
	input  wire        i_reset,
	input  wire        i_fast,
	input  wire  [3:0] i_srt,
	input  wire fdc_pkg::seek_req_t i_req,
	output fdc_pkg::seek_stat_t     o_stat
);

	logic [7:0]  ncn;
	logic [7:0]  pcn;
	logic [31:0] step_timer; // cycles left in this millisecond
	logic [3:0]  step_cnt;   // counts srt up to 15
	logic        busy;
	logic        int_pending;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			ncn         <= 8'd0;
			pcn         <= 8'd0;
			step_timer  <= 32'd0;
			step_cnt    <= 4'd0;
			busy        <= 1'b0;
			int_pending <= 1'b0;
		end else begin
			if (i_req.clear_int) begin
				int_pending <= 1'b0;
			end

			if (i_req.start) begin
				ncn        <= i_req.ncn;
				busy       <= 1'b1;
				step_timer <= `FDC_CYCLES_PER_MS;
				step_cnt   <= i_srt;
				if (i_fast) begin
					pcn <= i_req.ncn; // jump at once
				end
			end else if (i_req.error) begin
				ncn         <= i_req.ncn;
				int_pending <= 1'b1;
			end else if (busy) begin
				if (pcn == ncn) begin
					busy        <= 1'b0;
					int_pending <= 1'b1;
				end else if (i_fast) begin
					pcn <= ncn;
				end else if (step_timer != 32'd0) begin
					step_timer <= step_timer - 32'd1;
				end else if (step_cnt != 4'hf) begin
					step_cnt   <= step_cnt + 4'd1;
					step_timer <= `FDC_CYCLES_PER_MS;
				end else begin
					// one cylinder toward the target
					if (pcn > ncn) begin
						pcn <= pcn - 8'd1;
					end else begin
						pcn <= pcn + 8'd1;
					end
					step_cnt   <= i_srt;
					step_timer <= `FDC_CYCLES_PER_MS;
				end
			end
		end
	end

	always_comb begin
		o_stat.busy        = busy;
		o_stat.int_pending = int_pending;
		o_stat.at_target   = (pcn == ncn);
		o_stat.pcn         = pcn;
	end

endmodule

`default_nettype wire

// ==== sequencer/cmd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fdc_settings.svh"

module cmd_sequencer (
	input  wire        i_clk_sys,
	input  wire        i_reset,
	input  wire fdc_pkg::host_req_t  i_req,
	input  wire  [1:0] i_ready,
	input  wire  [1:0] i_motor,
	input  wire  [1:0] i_available,
	input  wire fdc_pkg::seek_stat_t i_seek_stat [2],
	output fdc_pkg::seek_req_t       o_seek_req [2],
	output logic [3:0] o_srt,
	output logic [7:0] o_status,
	output logic [7:0] o_data
);

	fdc_pkg::seq_state_t  state;
	fdc_pkg::fdc_opcode_t opcode;
	logic                 ds0;          // selected drive
	logic                 hds;          // head, sense drive status only
	logic                 result_state;
	logic [7:0]           status_next;
	logic [7:0]           st3;

	// ======================================================================
	// opcode decode
	// ======================================================================

	always_comb begin
		case (i_req.wdata)
			8'b000_00011: opcode = fdc_pkg::OP_SPECIFY;
			8'b000_00100: opcode = fdc_pkg::OP_SENSE_DRIVE;
			8'b000_00111: opcode = fdc_pkg::OP_RECALIBRATE;
			8'b000_01111: opcode = fdc_pkg::OP_SEEK;
			8'b000_01000: opcode = fdc_pkg::OP_SENSE_INT;
			default:      opcode = fdc_pkg::OP_INVALID; // incl. the dropped data commands
		endcase
	end

	// ======================================================================
	// main status and ST3
	// ======================================================================

	always_comb begin
		result_state = (state == fdc_pkg::INVALID) || (state == fdc_pkg::SENSE_INT) ||
			(state == fdc_pkg::SENSE_INT2) || (state == fdc_pkg::SENSE_DRIVE_RD);
		status_next = 8'h00;
		status_next[`FDC_MS_RQM] = 1'b1; // never any back-pressure
		status_next[`FDC_MS_DIO] = result_state;
		status_next[`FDC_MS_CB]  = (state != fdc_pkg::IDLE);
		status_next[`FDC_MS_D1B] = i_seek_stat[1].busy;
		status_next[`FDC_MS_D0B] = i_seek_stat[0].busy;
	end

	// wp and two-sided bits always 0 here
	assign st3 = {2'b00, i_available[ds0], i_ready[ds0] & (i_seek_stat[ds0].pcn == 8'd0),
		1'b0, hds, 1'b0, ds0};

	// ======================================================================
	// command FSM
	// ======================================================================

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			state    <= fdc_pkg::IDLE;
			ds0      <= 1'b0;
			hds      <= 1'b0;
			o_srt    <= `FDC_SRT_RESET;
			o_status <= 8'h80;
			for (int i = 0; i < 2; i++) begin
				o_seek_req[i] <= '0;
			end
		end else begin
			o_status <= status_next;

			// seek requests are single-cycle pulses
			for (int i = 0; i < 2; i++) begin
				o_seek_req[i].start     <= 1'b0;
				o_seek_req[i].clear_int <= 1'b0;
				o_seek_req[i].error     <= 1'b0;
			end

			case (state)
				fdc_pkg::IDLE:
					if (i_req.wr_stb) begin
						case (opcode)
							fdc_pkg::OP_SPECIFY:     state <= fdc_pkg::SPECIFY1;
							fdc_pkg::OP_SENSE_DRIVE: state <= fdc_pkg::SENSE_DRIVE;
							fdc_pkg::OP_RECALIBRATE: state <= fdc_pkg::RECAL;
							fdc_pkg::OP_SEEK:        state <= fdc_pkg::SEEK1;
							fdc_pkg::OP_SENSE_INT:   state <= fdc_pkg::SENSE_INT;
							default:                 state <= fdc_pkg::INVALID;
						endcase
					end else if (i_req.rd_stb) begin
						o_data <= 8'hff; // nothing to read
					end

				fdc_pkg::SPECIFY1:
					if (i_req.wr_stb) begin
						o_srt <= i_req.wdata[7:4]; // hut ignored
						state <= fdc_pkg::SPECIFY2;
					end

				fdc_pkg::SPECIFY2:
					if (i_req.wr_stb) begin
						state <= fdc_pkg::IDLE; // hlt/nd byte dropped
					end

				fdc_pkg::SENSE_DRIVE:
					if (i_req.wr_stb) begin
						ds0   <= i_req.wdata[0];
						hds   <= i_req.wdata[2];
						state <= fdc_pkg::SENSE_DRIVE_RD;
					end

				fdc_pkg::SENSE_DRIVE_RD:
					if (i_req.rd_stb) begin
						o_data <= st3;
						state  <= fdc_pkg::IDLE;
					end

				fdc_pkg::RECAL:
					if (i_req.wr_stb) begin
						ds0 <= i_req.wdata[0];
						o_seek_req[i_req.wdata[0]].clear_int <= 1'b1;
						o_seek_req[i_req.wdata[0]].start     <= 1'b1;
						o_seek_req[i_req.wdata[0]].ncn       <= 8'd0;
						state <= fdc_pkg::IDLE;
					end

				fdc_pkg::SEEK1:
					if (i_req.wr_stb) begin
						ds0 <= i_req.wdata[0];
						o_seek_req[i_req.wdata[0]].clear_int <= 1'b1;
						state <= fdc_pkg::SEEK2;
					end

				fdc_pkg::SEEK2:
					if (i_req.wr_stb) begin
						o_seek_req[ds0].ncn <= i_req.wdata;
						// cylinder 0 is always reachable
						if ((i_req.wdata == 8'd0) || (i_motor[ds0] && i_ready[ds0] &&
							(i_req.wdata < `FDC_MAX_TRACKS))) begin
							o_seek_req[ds0].start <= 1'b1;
						end else begin
							o_seek_req[ds0].error <= 1'b1;
						end
						state <= fdc_pkg::IDLE;
					end

				fdc_pkg::SENSE_INT:
					if (i_req.rd_stb) begin
						if (i_seek_stat[0].int_pending) begin
							o_data <= (i_seek_stat[0].at_target && i_ready[0]) ? 8'h20 : 8'he8;
							ds0    <= 1'b0;
							state  <= fdc_pkg::SENSE_INT2;
						end else if (i_seek_stat[1].int_pending) begin
							o_data <= (i_seek_stat[1].at_target && i_ready[1]) ? 8'h21 : 8'he9;
							ds0    <= 1'b1;
							state  <= fdc_pkg::SENSE_INT2;
						end else begin
							o_data <= 8'h80; // no interrupt pending
							state  <= fdc_pkg::IDLE;
						end
					end

				fdc_pkg::SENSE_INT2:
					if (i_req.rd_stb) begin
						o_data <= i_seek_stat[ds0].pcn;
						o_seek_req[ds0].clear_int <= 1'b1;
						state <= fdc_pkg::IDLE;
					end

				fdc_pkg::INVALID:
					if (i_req.rd_stb) begin
						o_data <= 8'h80; // ST0 invalid command
						state  <= fdc_pkg::IDLE;
					end

				default:
					state <= fdc_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/host_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module host_port (
	input  wire        i_clk_sys,
	input  wire        i_reset,
	input  wire        i_a0,
	input  wire        i_nrd,
	input  wire        i_nwr,
	input  wire  [7:0] i_din,
	input  wire  [7:0] i_status,
	input  wire  [7:0] i_data,
	output fdc_pkg::host_req_t o_req,
	output logic [7:0] o_dout
);

	logic wr_cond;
	logic rd_cond;
	logic old_wr;
	logic old_rd;

	// only one strobe low at a time counts
	assign wr_cond = ~i_nwr & i_nrd;
	assign rd_cond = i_nwr & ~i_nrd;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			old_wr <= 1'b0;
			old_rd <= 1'b0;
			o_req  <= '0;
		end else begin
			old_wr       <= wr_cond;
			old_rd       <= rd_cond;
			o_req.wr_stb <= wr_cond & ~old_wr & i_a0; // rising edge on the data reg only
			o_req.rd_stb <= rd_cond & ~old_rd & i_a0;
			o_req.wdata  <= i_din;
		end
	end

	// a0 low selects the main status register
	assign o_dout = i_a0 ? i_data : i_status;

endmodule

`default_nettype wire

// ==== common/fdc_pkg.sv ====
`default_nettype none

package fdc_pkg;

	// sequencer states
	typedef enum logic [4:0] {
		IDLE,
		SPECIFY1,
		SPECIFY2,
		SENSE_DRIVE,
		SENSE_DRIVE_RD,
		RECAL,
		SEEK1,
		SEEK2,
		SENSE_INT,
		SENSE_INT2,
		INVALID
	} seq_state_t;

	// commands still handled by this core
	typedef enum logic [2:0] {
		OP_SPECIFY,
		OP_SENSE_DRIVE,
		OP_RECALIBRATE,
		OP_SEEK,
		OP_SENSE_INT,
		OP_INVALID
	} fdc_opcode_t;

	// host port to sequencer
	typedef struct packed {
		logic       wr_stb; // data register written
		logic       rd_stb; // data register read
		logic [7:0] wdata;
	} host_req_t;

	// sequencer to one seek unit
	typedef struct packed {
		logic       start;
		logic       clear_int;
		logic       error;     // refused seek sets the interrupt only
		logic [7:0] ncn;       // target cylinder
	} seek_req_t;

	// seek unit back to sequencer
	typedef struct packed {
		logic       busy;
		logic       int_pending;
		logic       at_target;
		logic [7:0] pcn;       // present cylinder
	} seek_stat_t;

endpackage

`default_nettype wire

// ==== common/fdc_settings.svh ====
`ifndef FDC_SETTINGS_SVH
`define FDC_SETTINGS_SVH

// ==========================================================================
// timing and limits
// ==========================================================================

// clock cycles per step-rate millisecond (8 MHz part)
`define FDC_CYCLES_PER_MS 32'd4000

// highest seekable cylinder plus one
`define FDC_MAX_TRACKS 8'd80

// step-rate code after reset
`define FDC_SRT_RESET 4'd4

// ==========================================================================
// main status register bits
// ==========================================================================

`define FDC_MS_D0B 0 // drive 0 seeking
`define FDC_MS_D1B 1 // drive 1 seeking
`define FDC_MS_CB  4 // command busy
`define FDC_MS_DIO 6 // set when data flows to the host
`define FDC_MS_RQM 7 // request for master

`endif
